// File: hw/csi_pkg.sv
`default_nettype none

package csi_pkg;

	//////////////////////////////////////////////////
	// datapath widths
	//////////////////////////////////////////////////

	typedef logic [3:0]  nibble_t;
	typedef logic [7:0]  byte_t;
	// byte 0 of the merged word sits in bits 7:0
	typedef logic [31:0] word_t;
	// {ecc[31:24], word count[23:8], vc[7:6], data type[5:0]}
	typedef logic [31:0] header_t;
	typedef logic [5:0]  dtype_t;
	typedef logic [15:0] wcount_t;
	typedef logic [15:0] crc_t;
	typedef logic [16:0] addr_t;
	typedef logic [15:0] coord_t;

	//////////////////////////////////////////////////
	// protocol constants
	//////////////////////////////////////////////////

	localparam byte_t  SYNC_BYTE      = 8'hB8;

	localparam dtype_t DT_FRAME_START = 6'h00;
	localparam dtype_t DT_FRAME_END   = 6'h01;
	// anything at or above this is a long packet
	localparam dtype_t DT_LONG_MIN    = 6'h10;
	localparam dtype_t DT_RAW8        = 6'h2A;

	// x^16+x^12+x^5+1, bit reversed for lsb-first shifting
	localparam crc_t CRC_INIT           = 16'hFFFF;
	localparam crc_t CRC_POLY_REFLECTED = 16'h8408;

	// header ecc columns, parity bits p5..p0 covering header bit i
	localparam logic [5:0] ECC_COL [24] = '{
		6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
		6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
		6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
	};

	// 320x240 words, write address wraps here
	localparam int unsigned FRAME_WORDS = 76800;

endpackage

`default_nettype wire

// File: hw/lane_aligner.sv
`default_nettype none

module lane_aligner (
	input  wire                mipi_clk_2,
	input  wire                reset,
	input  wire                hs_active_i,
	input  wire csi_pkg::nibble_t nibble_i,
	output csi_pkg::byte_t     byte_o,
	output logic               byte_stb_o
);

	//////////////////////////////////////////////////
	// two-nibble window
	//////////////////////////////////////////////////

	// newest nibble enters at the top, earliest bit ends up in bit 0
	csi_pkg::byte_t win_q;

	always_ff @(posedge mipi_clk_2) begin
		win_q <= {nibble_i, win_q[7:4]};
	end

	//////////////////////////////////////////////////
	// sync search and phase lock
	//////////////////////////////////////////////////

	// free running slot, tells the two nibble phases apart
	logic slot_q;
	logic locked_q;
	// slot on which the sync byte was seen complete
	logic phase_q;
	logic stb_q;
	logic sync_hit;

	assign sync_hit = (win_q == csi_pkg::SYNC_BYTE);

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			slot_q   <= 1'b0;
			locked_q <= 1'b0;
			phase_q  <= 1'b0;
			stb_q    <= 1'b0;
		end else begin
			slot_q <= ~slot_q;

			// sync can land on either slot, remember which one
			if (!locked_q && sync_hit) begin
				locked_q <= 1'b1;
				phase_q  <= slot_q;
			end

			// window holds a whole byte on every slot equal to phase_q
			stb_q <= locked_q && (slot_q != phase_q);
		end
	end

	assign byte_o     = win_q;
	assign byte_stb_o = stb_q;

endmodule

`default_nettype wire

// File: hw/header_ecc.sv
`default_nettype none

module header_ecc (
	input  wire csi_pkg::header_t header_raw_i,
	output csi_pkg::header_t      header_fixed_o,
	output logic                  header_ok_o
);

	//////////////////////////////////////////////////
	// parity over the 24 header bits
	//////////////////////////////////////////////////

	logic [5:0] parity;

	// each set bit folds its column into p5..p0
	always_comb begin
		parity = 6'h00;
		for (int i = 0; i < 24; i++) begin
			if (header_raw_i[i]) begin
				parity = parity ^ csi_pkg::ECC_COL[i];
			end
		end
	end

	//////////////////////////////////////////////////
	// syndrome and single-bit correction
	//////////////////////////////////////////////////

	// ecc bits 7:6 are reserved as zero, so they take part in the syndrome
	logic [7:0] syndrome;

	assign syndrome = {2'b00, parity} ^ header_raw_i[31:24];

	logic [23:0] flip;

	// at most one column can match a nonzero syndrome
	always_comb begin
		flip = 24'h000000;
		for (int i = 0; i < 24; i++) begin
			if (syndrome == {2'b00, csi_pkg::ECC_COL[i]}) begin
				flip[i] = 1'b1;
			end
		end
	end

	// ecc byte is passed through untouched
	assign header_fixed_o = header_raw_i ^ {8'h00, flip};

	// clean header or one correctable data bit
	assign header_ok_o = (syndrome == 8'h00) || (|flip);

endmodule

`default_nettype wire

// File: hw/packet_parser.sv
`default_nettype none

module packet_parser (
	input  wire                   mipi_clk_2,
	input  wire                   reset,
	input  wire                   hs_active_i,
	input  wire csi_pkg::byte_t   lane0_byte_i,
	input  wire csi_pkg::byte_t   lane1_byte_i,
	input  wire                   lane0_stb_i,
	input  wire                   lane1_stb_i,
	output csi_pkg::header_t      header_raw_o,
	input  wire csi_pkg::header_t header_fixed_i,
	input  wire                   header_ok_i,
	output logic                  frame_start_o,
	output logic                  frame_end_o,
	output logic                  line_start_o,
	output csi_pkg::word_t        payload_o,
	output logic                  payload_stb_o,
	output csi_pkg::crc_t         crc_rx_o,
	output logic                  crc_stb_o
);

	typedef enum logic [1:0] {
		ST_HEADER,
		ST_PAYLOAD,
		ST_CRC,
		ST_IGNORE
	} state_t;

	//////////////////////////////////////////////////
	// word assembly, lane0 lane1 lane0 lane1
	//////////////////////////////////////////////////

	logic           pair_stb;
	logic           half_q;
	logic [15:0]    low_q;
	logic           word_stb;
	csi_pkg::word_t word_c;

	// both lanes strobe together, skew is not handled
	assign pair_stb = lane0_stb_i && lane1_stb_i;
	assign word_stb = pair_stb && half_q;
	assign word_c   = {lane1_byte_i, lane0_byte_i, low_q};

	always_ff @(posedge mipi_clk_2) begin
		if (pair_stb && !half_q) begin
			low_q <= {lane1_byte_i, lane0_byte_i};
		end
		if (word_stb) begin
			payload_o <= word_c;
			crc_rx_o  <= word_c[15:0];
		end
	end

	// ecc block answers within the same cycle
	assign header_raw_o = word_c;

	csi_pkg::dtype_t  dtype_c;
	csi_pkg::wcount_t wcount_c;

	assign dtype_c  = header_fixed_i[5:0];
	assign wcount_c = header_fixed_i[23:8];

	//////////////////////////////////////////////////
	// packet sequencing
	//////////////////////////////////////////////////

	state_t           state_q;
	logic             raw8_q;
	csi_pkg::wcount_t words_left_q;

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			state_q       <= ST_HEADER;
			half_q        <= 1'b0;
			raw8_q        <= 1'b0;
			words_left_q  <= '0;
			frame_start_o <= 1'b0;
			frame_end_o   <= 1'b0;
			line_start_o  <= 1'b0;
			payload_stb_o <= 1'b0;
			crc_stb_o     <= 1'b0;
		end else begin
			frame_start_o <= 1'b0;
			frame_end_o   <= 1'b0;
			line_start_o  <= 1'b0;
			payload_stb_o <= 1'b0;
			crc_stb_o     <= 1'b0;

			if (pair_stb) begin
				half_q <= ~half_q;
			end

			if (word_stb) begin
				case (state_q)
					ST_HEADER: begin
						if (!header_ok_i) begin
							state_q <= ST_IGNORE;
						end else if (dtype_c >= csi_pkg::DT_LONG_MIN) begin
							// other long types are counted through silently
							raw8_q       <= (dtype_c == csi_pkg::DT_RAW8);
							line_start_o <= (dtype_c == csi_pkg::DT_RAW8);
							words_left_q <= wcount_c >> 2;
							state_q      <= (wcount_c[15:2] == '0) ? ST_CRC : ST_PAYLOAD;
						end else begin
							frame_start_o <= (dtype_c == csi_pkg::DT_FRAME_START);
							frame_end_o   <= (dtype_c == csi_pkg::DT_FRAME_END);
							state_q       <= ST_IGNORE;
						end
					end
					ST_PAYLOAD: begin
						payload_stb_o <= raw8_q;
						words_left_q  <= words_left_q - 1'b1;
						if (words_left_q == 16'd1) begin
							state_q <= ST_CRC;
						end
					end
					ST_CRC: begin
						// checksum in bits 15:0 of this word
						crc_stb_o <= raw8_q;
						state_q   <= ST_IGNORE;
					end
					default: begin
						// wait for the burst to end
						state_q <= ST_IGNORE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/crc16_check.sv
`default_nettype none

module crc16_check (
	input  wire                 mipi_clk_2,
	input  wire                 reset,
	input  wire                 line_start_i,
	input  wire csi_pkg::word_t payload_i,
	input  wire                 payload_stb_i,
	input  wire csi_pkg::crc_t  crc_rx_i,
	input  wire                 crc_stb_i,
	output logic                crc_err_o
);

	//////////////////////////////////////////////////
	// 32 bits per step, lsb first
	//////////////////////////////////////////////////

	function automatic csi_pkg::crc_t crc_step32(
		input csi_pkg::crc_t  crc_in,
		input csi_pkg::word_t data
	);
		csi_pkg::crc_t crc;
		logic          fb;
		crc = crc_in;
		for (int i = 0; i < 32; i++) begin
			fb  = crc[0] ^ data[i];
			crc = crc >> 1;
			if (fb) begin
				crc = crc ^ csi_pkg::CRC_POLY_REFLECTED;
			end
		end
		return crc;
	endfunction

	csi_pkg::crc_t crc_q;
	csi_pkg::crc_t crc_next;

	assign crc_next = crc_step32(crc_q, payload_i);

	//////////////////////////////////////////////////
	// running crc and end of packet compare
	//////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			crc_q     <= csi_pkg::CRC_INIT;
			crc_err_o <= 1'b0;
		end else begin
			// one cycle pulse on mismatch
			crc_err_o <= crc_stb_i && (crc_q != crc_rx_i);

			if (line_start_i) begin
				crc_q <= csi_pkg::CRC_INIT;
			end else if (payload_stb_i) begin
				crc_q <= crc_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/line_writer.sv
`default_nettype none

module line_writer (
	input  wire                 mipi_clk_2,
	input  wire                 reset,
	input  wire                 frame_start_i,
	input  wire                 line_start_i,
	input  wire csi_pkg::word_t payload_i,
	input  wire                 payload_stb_i,
	output logic                wr_en_o,
	output csi_pkg::addr_t      wr_addr_o,
	output csi_pkg::word_t      wr_data_o,
	output csi_pkg::coord_t     col_o,
	output csi_pkg::coord_t     row_o
);

	localparam csi_pkg::addr_t ADDR_LAST = csi_pkg::addr_t'(csi_pkg::FRAME_WORDS - 1);

	//////////////////////////////////////////////////
	// position counters
	//////////////////////////////////////////////////

	csi_pkg::addr_t  addr_q;
	csi_pkg::coord_t col_q;
	csi_pkg::coord_t row_q;
	// first line of a frame stays on row 0
	logic            first_line_q;

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			addr_q       <= '0;
			col_q        <= '0;
			row_q        <= '0;
			first_line_q <= 1'b1;
			wr_en_o      <= 1'b0;
			wr_addr_o    <= '0;
			col_o        <= '0;
			row_o        <= '0;
		end else begin
			wr_en_o <= payload_stb_i;

			if (frame_start_i) begin
				addr_q       <= '0;
				col_q        <= '0;
				row_q        <= '0;
				first_line_q <= 1'b1;
			end else if (line_start_i) begin
				col_q        <= '0;
				first_line_q <= 1'b0;
				if (!first_line_q) begin
					row_q <= row_q + 1'b1;
				end
			end else if (payload_stb_i) begin
				// write lands at the current position, then step on
				wr_addr_o <= addr_q;
				col_o     <= col_q;
				row_o     <= row_q;
				addr_q    <= (addr_q == ADDR_LAST) ? '0 : addr_q + 1'b1;
				col_q     <= col_q + 1'b1;
			end
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (payload_stb_i) begin
			wr_data_o <= payload_i;
		end
	end

endmodule

`default_nettype wire

// File: hw/mipi_rx_top.sv
`default_nettype none

module mipi_rx_top (
	input  wire                   mipi_clk_2,
	input  wire                   reset,
	input  wire                   hs_active_i,
	input  wire csi_pkg::nibble_t lane0_nib_i,
	input  wire csi_pkg::nibble_t lane1_nib_i,
	output wire                   wr_en_o,
	output wire csi_pkg::addr_t   wr_addr_o,
	output wire csi_pkg::word_t   wr_data_o,
	output wire csi_pkg::coord_t  col_o,
	output wire csi_pkg::coord_t  row_o,
	output wire                   crc_err_o,
	output wire                   frame_end_o
);

	wire csi_pkg::byte_t   lane0_byte;
	wire csi_pkg::byte_t   lane1_byte;
	wire                   lane0_stb;
	wire                   lane1_stb;
	wire csi_pkg::header_t header_raw;
	wire csi_pkg::header_t header_fixed;
	wire                   header_ok;
	wire                   frame_start;
	wire                   line_start;
	wire csi_pkg::word_t   payload;
	wire                   payload_stb;
	wire csi_pkg::crc_t    crc_rx;
	wire                   crc_stb;

	//////////////////////////////////////////////////
	// lane byte recovery
	//////////////////////////////////////////////////

	lane_aligner u_lane0 (
		.mipi_clk_2  (mipi_clk_2),
		.reset       (reset),
		.hs_active_i (hs_active_i),
		.nibble_i    (lane0_nib_i),
		.byte_o      (lane0_byte),
		.byte_stb_o  (lane0_stb)
	);

	lane_aligner u_lane1 (
		.mipi_clk_2  (mipi_clk_2),
		.reset       (reset),
		.hs_active_i (hs_active_i),
		.nibble_i    (lane1_nib_i),
		.byte_o      (lane1_byte),
		.byte_stb_o  (lane1_stb)
	);

	//////////////////////////////////////////////////
	// packet layer
	//////////////////////////////////////////////////

	header_ecc u_ecc (
		.header_raw_i   (header_raw),
		.header_fixed_o (header_fixed),
		.header_ok_o    (header_ok)
	);

	packet_parser u_parser (
		.mipi_clk_2     (mipi_clk_2),
		.reset          (reset),
		.hs_active_i    (hs_active_i),
		.lane0_byte_i   (lane0_byte),
		.lane1_byte_i   (lane1_byte),
		.lane0_stb_i    (lane0_stb),
		.lane1_stb_i    (lane1_stb),
		.header_raw_o   (header_raw),
		.header_fixed_i (header_fixed),
		.header_ok_i    (header_ok),
		.frame_start_o  (frame_start),
		.frame_end_o    (frame_end_o),
		.line_start_o   (line_start),
		.payload_o      (payload),
		.payload_stb_o  (payload_stb),
		.crc_rx_o       (crc_rx),
		.crc_stb_o      (crc_stb)
	);

	crc16_check u_crc (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.line_start_i  (line_start),
		.payload_i     (payload),
		.payload_stb_i (payload_stb),
		.crc_rx_i      (crc_rx),
		.crc_stb_i     (crc_stb),
		.crc_err_o     (crc_err_o)
	);

	// frame buffer side
	line_writer u_writer (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.frame_start_i (frame_start),
		.line_start_i  (line_start),
		.payload_i     (payload),
		.payload_stb_i (payload_stb),
		.wr_en_o       (wr_en_o),
		.wr_addr_o     (wr_addr_o),
		.wr_data_o     (wr_data_o),
		.col_o         (col_o),
		.row_o         (row_o)
	);

endmodule

`default_nettype wire

// File: bench/csi_stim.svh
`ifndef CSI_STIM_SVH
`define CSI_STIM_SVH

// numerical recipes lcg
localparam logic [31:0] LCG_SEED = 32'h35ff3dde;
localparam logic [31:0] LCG_MUL  = 32'd1664525;
localparam logic [31:0] LCG_INC  = 32'd1013904223;

// crc-16 ccitt, reflected
localparam logic [15:0] CRC_POLY = 16'h8408;

localparam int IDLE_CYCLES  = 4;
localparam int DRAIN_CYCLES = 6;
localparam int NUM_TESTS    = 13;

typedef struct packed {
	csi_pkg::dtype_t dtype;
	logic [15:0]     wcount;
	logic            phase;
	logic            flip_en;
	logic [4:0]      flip_bit;
	logic            dbl_flip;
	logic            crc_bad;
	logic [8:0]      exp_writes;
	logic            exp_crc_err;
	logic            exp_frame_end;
} test_t;

// dtype, bytes, phase, flip, flip bit, double flip, bad crc | writes, crc err, frame end
localparam test_t TESTS [NUM_TESTS] = '{
	'{6'h00, 16'd0,   1'b0, 1'b0, 5'd0,  1'b0, 1'b0, 9'd0,   1'b0, 1'b0},
	'{6'h2A, 16'd640, 1'b0, 1'b0, 5'd0,  1'b0, 1'b0, 9'd160, 1'b0, 1'b0},
	'{6'h2A, 16'd640, 1'b1, 1'b0, 5'd0,  1'b0, 1'b0, 9'd160, 1'b0, 1'b0},
	'{6'h2A, 16'd64,  1'b0, 1'b1, 5'd0,  1'b0, 1'b0, 9'd16,  1'b0, 1'b0},
	'{6'h2A, 16'd64,  1'b1, 1'b1, 5'd6,  1'b0, 1'b0, 9'd16,  1'b0, 1'b0},
	'{6'h2A, 16'd64,  1'b0, 1'b1, 5'd13, 1'b0, 1'b0, 9'd16,  1'b0, 1'b0},
	'{6'h2A, 16'd64,  1'b1, 1'b1, 5'd23, 1'b0, 1'b0, 9'd16,  1'b0, 1'b0},
	'{6'h2A, 16'd64,  1'b0, 1'b0, 5'd4,  1'b1, 1'b0, 9'd0,   1'b0, 1'b0},
	'{6'h2A, 16'd64,  1'b1, 1'b0, 5'd0,  1'b0, 1'b1, 9'd16,  1'b1, 1'b0},
	'{6'h2B, 16'd80,  1'b1, 1'b0, 5'd0,  1'b0, 1'b0, 9'd0,   1'b0, 1'b0},
	'{6'h01, 16'd0,   1'b1, 1'b0, 5'd0,  1'b0, 1'b0, 9'd0,   1'b0, 1'b1},
	'{6'h00, 16'd0,   1'b0, 1'b0, 5'd0,  1'b0, 1'b0, 9'd0,   1'b0, 1'b0},
	'{6'h2A, 16'd64,  1'b0, 1'b0, 5'd0,  1'b0, 1'b0, 9'd16,  1'b0, 1'b0}
};

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * LCG_MUL + LCG_INC;
endfunction

// csi-2 hamming parity sets over header bits 23:0
function automatic logic [5:0] ecc_parity(input logic [23:0] d);
	logic [5:0] p;
	p[0] = ^(d & 24'hF12CB7);
	p[1] = ^(d & 24'hF2555B);
	p[2] = ^(d & 24'h749A6D);
	p[3] = ^(d & 24'hB8E38E);
	p[4] = ^(d & 24'hDF03F0);
	p[5] = ^(d & 24'hEFFC00);
	return p;
endfunction

function automatic logic [15:0] crc16_byte(input logic [15:0] crc_in, input logic [7:0] b);
	logic [15:0] crc;
	crc = crc_in ^ {8'h00, b};
	for (int k = 0; k < 8; k++) begin
		if (crc[0]) begin
			crc = (crc >> 1) ^ CRC_POLY;
		end else begin
			crc = crc >> 1;
		end
	end
	return crc;
endfunction

// sync byte, two bytes per lane per word, two tail bytes, two nibbles each
function automatic int burst_cycles(input test_t t);
	int words;
	words = 1;
	if (t.dtype >= csi_pkg::DT_LONG_MIN) begin
		words = words + int'(t.wcount) / 4 + 1;
	end
	return IDLE_CYCLES + DRAIN_CYCLES + int'(t.phase) + 2 * (3 + 2 * words);
endfunction

task automatic drive_idle(input int cycles);
	repeat (cycles) begin
		@(posedge mipi_clk_2);
		hs_active_i <= 1'b0;
		lane0_nib_i <= '0;
		lane1_nib_i <= '0;
	end
endtask

// bytes 0 and 2 of each word on lane 0, bytes 1 and 3 on lane 1
task automatic send_burst(input logic phase);
	csi_pkg::byte_t   l0 [$];
	csi_pkg::byte_t   l1 [$];
	csi_pkg::nibble_t n0 [$];
	csi_pkg::nibble_t n1 [$];
	l0.push_back(8'hB8);
	l1.push_back(8'hB8);
	foreach (pkt_words[i]) begin
		l0.push_back(pkt_words[i][7:0]);
		l1.push_back(pkt_words[i][15:8]);
		l0.push_back(pkt_words[i][23:16]);
		l1.push_back(pkt_words[i][31:24]);
	end
	// tail bytes flush the last lane strobes
	repeat (2) begin
		l0.push_back(8'h00);
		l1.push_back(8'h00);
	end
	if (phase) begin
		n0.push_back(4'h0);
		n1.push_back(4'h0);
	end
	foreach (l0[i]) begin
		n0.push_back(l0[i][3:0]);
		n0.push_back(l0[i][7:4]);
		n1.push_back(l1[i][3:0]);
		n1.push_back(l1[i][7:4]);
	end
	drive_idle(IDLE_CYCLES);
	foreach (n0[i]) begin
		@(posedge mipi_clk_2);
		hs_active_i <= 1'b1;
		lane0_nib_i <= n0[i];
		lane1_nib_i <= n1[i];
	end
	drive_idle(DRAIN_CYCLES);
endtask

`endif

// File: bench/mipi_rx_tb.sv
`default_nettype none

module mipi_rx_tb;

	logic                  mipi_clk_2;
	logic                  reset;
	logic                  hs_active_i;
	csi_pkg::nibble_t      lane0_nib_i;
	csi_pkg::nibble_t      lane1_nib_i;
	wire                   wr_en_o;
	wire csi_pkg::addr_t   wr_addr_o;
	wire csi_pkg::word_t   wr_data_o;
	wire csi_pkg::coord_t  col_o;
	wire csi_pkg::coord_t  row_o;
	wire                   crc_err_o;
	wire                   frame_end_o;

	typedef struct packed {
		csi_pkg::word_t  data;
		csi_pkg::addr_t  addr;
		csi_pkg::coord_t col;
		csi_pkg::coord_t row;
	} exp_write_t;

	exp_write_t      exp_q [$];
	exp_write_t      exp_w;
	csi_pkg::word_t  pkt_words [$];
	logic [31:0]     lcg_state;
	int              errors;
	int              writes_total;
	int              crc_err_total;
	int              frame_end_total;

	// reference position in the frame buffer
	csi_pkg::addr_t  ref_addr;
	csi_pkg::coord_t ref_col;
	csi_pkg::coord_t ref_row;
	logic            ref_first;

	`include "csi_stim.svh"

	mipi_rx_top DUT (
		.mipi_clk_2  (mipi_clk_2),
		.reset       (reset),
		.hs_active_i (hs_active_i),
		.lane0_nib_i (lane0_nib_i),
		.lane1_nib_i (lane1_nib_i),
		.wr_en_o     (wr_en_o),
		.wr_addr_o   (wr_addr_o),
		.wr_data_o   (wr_data_o),
		.col_o       (col_o),
		.row_o       (row_o),
		.crc_err_o   (crc_err_o),
		.frame_end_o (frame_end_o)
	);

	initial mipi_clk_2 = 1'b0;
	always #10 mipi_clk_2 = ~mipi_clk_2;

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input csi_pkg::word_t got,
		input csi_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input csi_pkg::addr_t got,
		input csi_pkg::addr_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_coord(input string name, input csi_pkg::coord_t got,
		input csi_pkg::coord_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// packet build and expected writes
	//////////////////////////////////////////////////

	task automatic build_packet(input test_t t);
		csi_pkg::header_t hdr;
		csi_pkg::word_t   data;
		logic [15:0]      crc;
		logic             hdr_ok;
		exp_write_t       e;
		pkt_words.delete();
		hdr_ok = !t.dbl_flip;
		hdr[23:0] = {t.wcount, 2'b00, t.dtype};
		hdr[31:24] = {2'b00, ecc_parity(hdr[23:0])};
		if (t.flip_en) begin
			hdr[t.flip_bit] = ~hdr[t.flip_bit];
		end
		if (t.dbl_flip) begin
			hdr[t.flip_bit] = ~hdr[t.flip_bit];
			hdr[t.flip_bit + 5'd1] = ~hdr[t.flip_bit + 5'd1];
		end
		pkt_words.push_back(hdr);
		if (hdr_ok && t.dtype == csi_pkg::DT_FRAME_START) begin
			ref_addr = '0;
			ref_col = '0;
			ref_row = '0;
			ref_first = 1'b1;
		end
		// first line of a frame keeps row 0
		if (hdr_ok && t.dtype == csi_pkg::DT_RAW8) begin
			ref_col = '0;
			if (!ref_first) begin
				ref_row++;
			end
			ref_first = 1'b0;
		end
		if (t.dtype >= csi_pkg::DT_LONG_MIN) begin
			crc = 16'hFFFF;
			for (int w = 0; w < int'(t.wcount) / 4; w++) begin
				lcg_state = lcg_next(lcg_state);
				data = lcg_state;
				pkt_words.push_back(data);
				for (int b = 0; b < 4; b++) begin
					crc = crc16_byte(crc, data[8 * b +: 8]);
				end
				if (hdr_ok && t.dtype == csi_pkg::DT_RAW8) begin
					e.data = data;
					e.addr = ref_addr;
					e.col = ref_col;
					e.row = ref_row;
					exp_q.push_back(e);
					ref_addr = (ref_addr == 17'(csi_pkg::FRAME_WORDS - 1)) ? '0 : ref_addr + 17'd1;
					ref_col++;
				end
			end
			if (t.crc_bad) begin
				crc = crc ^ 16'h0001;
			end
			pkt_words.push_back({16'h0000, crc});
		end
	endtask

	//////////////////////////////////////////////////
	// write monitor
	//////////////////////////////////////////////////

	always @(negedge mipi_clk_2) begin
		if (!reset && wr_en_o) begin
			writes_total++;
			if (exp_q.size() == 0) begin
				$display("unexpected frame buffer write at time %0t, address %0d",
					$time, wr_addr_o);
				errors++;
			end else begin
				exp_w = exp_q.pop_front();
				check_word("wr_data_o", wr_data_o, exp_w.data);
				check_addr("wr_addr_o", wr_addr_o, exp_w.addr);
				check_coord("col_o", col_o, exp_w.col);
				check_coord("row_o", row_o, exp_w.row);
			end
		end
		if (!reset && crc_err_o) begin
			crc_err_total++;
		end
		if (!reset && frame_end_o) begin
			frame_end_total++;
		end
	end

	initial begin : watchdog
		longint limit;
		limit = 0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			limit = limit + burst_cycles(TESTS[i]);
		end
		limit = limit * 2 + 1000;
		#(limit * 20);
		$display("run stopped by the watchdog after %0d cycles", limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	//////////////////////////////////////////////////
	// test loop
	//////////////////////////////////////////////////

	initial begin
		test_t t;
		int    err_before;
		int    writes_before;
		int    crc_before;
		int    fe_before;
		int    pass_count;
		int    fail_count;
		reset = 1'b1;
		hs_active_i = 1'b0;
		lane0_nib_i = '0;
		lane1_nib_i = '0;
		errors = 0;
		writes_total = 0;
		crc_err_total = 0;
		frame_end_total = 0;
		pass_count = 0;
		fail_count = 0;
		lcg_state = LCG_SEED;
		ref_addr = '0;
		ref_col = '0;
		ref_row = '0;
		ref_first = 1'b1;
		repeat (3) @(posedge mipi_clk_2);
		reset <= 1'b0;

		for (int i = 0; i < NUM_TESTS; i++) begin
			t = TESTS[i];
			err_before = errors;
			writes_before = writes_total;
			crc_before = crc_err_total;
			fe_before = frame_end_total;
			build_packet(t);
			send_burst(t.phase);
			check_count("wr_en_o pulses", writes_total - writes_before, int'(t.exp_writes));
			check_count("writes still queued", exp_q.size(), 0);
			check_bit("crc_err_o seen", crc_err_total != crc_before, t.exp_crc_err);
			check_bit("frame_end_o seen", frame_end_total != fe_before, t.exp_frame_end);
			if (crc_err_total - crc_before > 1 || frame_end_total - fe_before > 1) begin
				$display("test %0d: a pulse came more than once in one burst", i);
				errors++;
			end
			if (errors == err_before) begin
				pass_count++;
			end else begin
				fail_count++;
			end
			$display("test %0d: dtype %h, %0d bytes, phase %0d, %0d writes, %s", i, t.dtype,
				t.wcount, t.phase, writes_total - writes_before,
				(errors == err_before) ? "ok" : "mismatch");
		end

		$display("tests passed %0d, tests failed %0d", pass_count, fail_count);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mipi_rx_top.f
+incdir+bench
hw/csi_pkg.sv
hw/lane_aligner.sv
hw/header_ecc.sv
hw/packet_parser.sv
hw/crc16_check.sv
hw/line_writer.sv
hw/mipi_rx_top.sv
bench/mipi_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the mipi rx testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	--top-module mipi_rx_tb \
	-f mipi_rx_top.f \
	-o mipi_rx_sim \
	&& ./obj_dir/mipi_rx_sim | tee sim.log \
	|| { echo "build or run of mipi_rx_sim failed"; exit 1; }

grep -qF '*** TEST PASSED ***' sim.log \
	&& echo "mipi_rx_tb: simulation passed" \
	|| { echo "mipi_rx_tb: simulation failed, see sim.log"; exit 1; }
